/* design/spi_pkg.sv */
package spi_pkg;

    // register offsets
    localparam logic [11:0] SPI_CR1 = 12'h000;
    localparam logic [11:0] SPI_CR2 = 12'h004;
    localparam logic [11:0] SPI_SR  = 12'h008;
    localparam logic [11:0] SPI_DR  = 12'h00C;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic [3:0] rsvd_hi;
        logic       dff;
        logic [2:0] rsvd_lo;
        logic       lsbfirst;
        logic       spe;
        logic [2:0] br;
        logic       mstr;
        logic       cpol;
        logic       cpha;
    } spi_cr1_t;

    typedef struct packed {
        logic       txeie;
        logic       rxneie;
        logic       errie;
        logic [1:0] rsvd;
        logic       ssoe;
        logic       txdmaen;
        logic       rxdmaen;
    } spi_cr2_t;

    // error flags are not implemented and read as zero
    typedef struct packed {
        logic       bsy;
        logic [4:0] rsvd;
        logic       rxne;
        logic       txe;
    } spi_sr_t;

    // pwdata seen as CR1 or CR2 depending on paddr
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] unused;
            spi_cr1_t    cr1;
        } cr1_w;
        struct packed {
            logic [23:0] unused;
            spi_cr2_t    cr2;
        } cr2_w;
    } spi_wdata_u;

    typedef struct packed {
        logic       cpha;
        logic       cpol;
        logic [2:0] br;
        logic       spe;
        logic       lsbfirst;
        logic       dff;
        logic       ssoe;
    } spi_cfg_t;

endpackage

/* design/spi_regs.sv */
`timescale 1ns/1ns

module spi_regs (
    input  logic                clk,
    input  logic                rstn,
    input  spi_pkg::apb_req_t   apb_req_i,
    input  logic                tx_pop_i,
    input  logic                rx_pop_i,
    input  logic                busy_i,
    input  logic [15:0]         rx_data_i,
    input  logic                dma_txreq_i,
    input  logic [15:0]         dma_txbuff_i,
    input  logic                dma_rxreq_i,
    output spi_pkg::apb_rsp_t   apb_rsp_o,
    output spi_pkg::spi_cfg_t   cfg_o,
    output logic                tx_full_o,
    output logic [15:0]         tx_data_o,
    output logic                dma_txe_o,
    output logic                dma_rxne_o,
    output logic [15:0]         dma_rxbuff_o,
    output logic                irq_o
);

    spi_pkg::spi_wdata_u wdata;
    spi_pkg::spi_cr1_t   cr1_q;
    spi_pkg::spi_cr2_t   cr2_q;
    spi_pkg::spi_sr_t    sr;

    logic        wr_setup;
    logic        rd_setup;
    logic        dr_wr;
    logic        dr_rd;
    logic        tx_accept;
    logic        rx_release;
    logic        txe_q;
    logic        rxne_q;
    logic        bsy_q;
    logic        rx_pop_q;
    logic [15:0] tx_buf_q;
    logic [15:0] rx_buf_q;
    logic [31:0] rdata;

    // both directions act in the setup phase
    assign wr_setup = apb_req_i.psel & ~apb_req_i.penable & apb_req_i.pwrite;
    assign rd_setup = apb_req_i.psel & ~apb_req_i.penable & ~apb_req_i.pwrite;
    assign dr_wr    = wr_setup & (apb_req_i.paddr == spi_pkg::SPI_DR);
    assign dr_rd    = rd_setup & (apb_req_i.paddr == spi_pkg::SPI_DR);

    assign wdata = apb_req_i.pwdata;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cr1_q <= spi_pkg::spi_cr1_t'(16'h0004);
        end else if (wr_setup && apb_req_i.paddr == spi_pkg::SPI_CR1) begin
            cr1_q.cpha <= wdata.cr1_w.cr1.cpha;
            cr1_q.cpol <= wdata.cr1_w.cr1.cpol;
            cr1_q.spe  <= wdata.cr1_w.cr1.spe;
            // frame format locked while enabled
            if (!cr1_q.spe) begin
                cr1_q.br       <= wdata.cr1_w.cr1.br;
                cr1_q.lsbfirst <= wdata.cr1_w.cr1.lsbfirst;
                cr1_q.dff      <= wdata.cr1_w.cr1.dff;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cr2_q <= spi_pkg::spi_cr2_t'(8'h04);
        end else if (wr_setup && apb_req_i.paddr == spi_pkg::SPI_CR2) begin
            cr2_q.rxdmaen <= wdata.cr2_w.cr2.rxdmaen;
            cr2_q.txdmaen <= wdata.cr2_w.cr2.txdmaen;
            cr2_q.ssoe    <= wdata.cr2_w.cr2.ssoe;
            cr2_q.errie   <= wdata.cr2_w.cr2.errie;
            cr2_q.rxneie  <= wdata.cr2_w.cr2.rxneie;
            cr2_q.txeie   <= wdata.cr2_w.cr2.txeie;
        end
    end

    always_comb begin
        cfg_o.cpha     = cr1_q.cpha;
        cfg_o.cpol     = cr1_q.cpol;
        cfg_o.br       = cr1_q.br;
        cfg_o.spe      = cr1_q.spe;
        cfg_o.lsbfirst = cr1_q.lsbfirst;
        cfg_o.dff      = cr1_q.dff;
        cfg_o.ssoe     = cr2_q.ssoe;
    end

    // apb write wins over dma on the transmit buffer
    assign tx_accept = txe_q & (dr_wr | dma_txreq_i);

    always_ff @(posedge clk) begin
        if (txe_q && dr_wr) begin
            tx_buf_q <= wdata.raw[15:0];
        end else if (txe_q && dma_txreq_i) begin
            tx_buf_q <= dma_txbuff_i;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            txe_q <= 1'b1;
        end else if (tx_accept) begin
            txe_q <= 1'b0;
        end else if (tx_pop_i) begin
            txe_q <= 1'b1;
        end
    end

    // shifter word settles one cycle after rx_pop
    assign rx_release = rxne_q & (dr_rd | dma_rxreq_i);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rx_pop_q <= 1'b0;
            bsy_q    <= 1'b0;
            rx_buf_q <= 16'h0;
        end else begin
            rx_pop_q <= rx_pop_i;
            bsy_q    <= busy_i;
            if (rx_pop_q) begin
                rx_buf_q <= rx_data_i;
            end
        end
    end

    // a new frame wins over a read in the same cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rxne_q <= 1'b0;
        end else if (rx_pop_q) begin
            rxne_q <= 1'b1;
        end else if (rx_release) begin
            rxne_q <= 1'b0;
        end
    end

    always_comb begin
        sr      = '0;
        sr.txe  = txe_q;
        sr.rxne = rxne_q;
        sr.bsy  = bsy_q;
    end

    always_comb begin
        case (apb_req_i.paddr)
            spi_pkg::SPI_CR1: rdata = {16'h0, cr1_q};
            spi_pkg::SPI_CR2: rdata = {24'h0, cr2_q};
            spi_pkg::SPI_SR:  rdata = {24'h0, sr};
            spi_pkg::SPI_DR:  rdata = {16'h0, rx_buf_q};
            default:          rdata = 32'h0;
        endcase
    end

    // prdata only valid in the access cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            apb_rsp_o.prdata <= 32'h0;
        end else begin
            apb_rsp_o.prdata <= rd_setup ? rdata : 32'h0;
        end
    end

    assign tx_full_o    = ~txe_q;
    assign tx_data_o    = tx_buf_q;
    assign dma_txe_o    = txe_q;
    assign dma_rxne_o   = rxne_q;
    assign dma_rxbuff_o = rx_buf_q;

    assign irq_o = (cr2_q.txeie & txe_q) | (cr2_q.rxneie & rxne_q);

endmodule

/* design/spi_engine.sv */
`timescale 1ns/1ns

module spi_engine (
    input  logic              clk,
    input  logic              rstn,
    input  spi_pkg::spi_cfg_t cfg_i,
    input  logic              tx_full_i,
    output logic              tx_pop_o,
    output logic              rx_pop_o,
    output logic              busy_o,
    output logic              load_o,
    output logic              shift_tx_o,
    output logic              sample_rx_o,
    output logic              sclk_o,
    output logic              nss_o
);

    localparam logic [1:0] ST_OFF   = 2'b00;
    localparam logic [1:0] ST_IDLE  = 2'b01;
    localparam logic [1:0] ST_START = 2'b10;
    localparam logic [1:0] ST_DATA  = 2'b11;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic [7:0] div_q;
    logic [7:0] reload_val;
    logic [7:0] half_val;
    logic       div_zero;
    logic       div_half;
    logic       div_reload;
    logic [3:0] bit_q;
    logic       bit_zero;
    logic       frame_end;
    logic       idle_pop;
    logic       sclk_pre;
    logic       nss_pre;

    // one bit lasts 2^(br+1) clocks
    assign reload_val = (8'd1 << ({1'b0, cfg_i.br} + 4'd1)) - 8'd1;
    assign half_val   = 8'd1 << cfg_i.br;
    assign div_zero   = (div_q == 8'd0);
    assign div_half   = (div_q == half_val);
    assign bit_zero   = (bit_q == 4'd0);

    assign idle_pop  = (state_q == ST_IDLE) & cfg_i.spe & div_zero & tx_full_i;
    assign frame_end = (state_q == ST_DATA) & div_zero & bit_zero;

    // cpha 1 chains the next word with no gap
    assign tx_pop_o = idle_pop | (frame_end & cfg_i.cpha & tx_full_i);
    assign rx_pop_o = frame_end;
    assign load_o   = tx_pop_o;
    assign busy_o   = (state_q == ST_START) | (state_q == ST_DATA);

    assign div_reload = ((state_q == ST_OFF) & cfg_i.spe) | idle_pop |
                        ((state_q == ST_START) & div_half) |
                        ((state_q == ST_DATA) & div_zero);

    // cpha picks which point shifts and which samples
    assign shift_tx_o  = (state_q == ST_DATA) & (cfg_i.cpha ? div_zero : div_half);
    assign sample_rx_o = ((state_q == ST_START) & ~cfg_i.cpha & div_half) |
                         ((state_q == ST_DATA) & (cfg_i.cpha ? div_half : div_zero));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            div_q <= 8'd0;
        end else if (div_reload) begin
            div_q <= reload_val;
        end else if (!div_zero) begin
            div_q <= div_q - 8'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bit_q <= 4'd0;
        end else if (tx_pop_o) begin
            bit_q <= cfg_i.dff ? 4'd15 : 4'd7;
        end else if (state_q == ST_DATA && div_zero && !bit_zero) begin
            bit_q <= bit_q - 4'd1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_OFF: begin
                if (cfg_i.spe) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (!cfg_i.spe) begin
                    state_d = ST_OFF;
                end else if (idle_pop) begin
                    state_d = ST_START;
                end
            end
            ST_START: begin
                if (div_half) begin
                    state_d = ST_DATA;
                end
            end
            default: begin
                if (frame_end && !(cfg_i.cpha && tx_full_i)) begin
                    state_d = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= ST_OFF;
        end else begin
            state_q <= state_d;
        end
    end

    // high in the first half of every bit period
    assign sclk_pre = (state_q == ST_DATA) & div_q[cfg_i.br];
    assign nss_pre  = (state_q == ST_OFF) | ~cfg_i.ssoe;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sclk_o <= 1'b0;
            nss_o  <= 1'b1;
        end else begin
            sclk_o <= sclk_pre ^ cfg_i.cpol;
            nss_o  <= nss_pre;
        end
    end

endmodule

/* design/spi_shifter.sv */
`timescale 1ns/1ns

module spi_shifter (
    input  logic              clk,
    input  logic              rstn,
    input  spi_pkg::spi_cfg_t cfg_i,
    input  logic              load_i,
    input  logic              shift_tx_i,
    input  logic              sample_rx_i,
    input  logic              rx_pop_i,
    input  logic [15:0]       tx_data_i,
    input  logic              miso_i,
    output logic              mosi_o,
    output logic [15:0]       rx_data_o
);

    logic [15:0] tx_q;
    logic [15:0] rx_q;
    logic        sample_q;
    logic        rx_pop_q;
    logic        mosi_pre;

    // upper byte masked for 8 bit frames
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx_q <= 16'h0;
        end else if (load_i) begin
            tx_q <= {tx_data_i[15:8] & {8{cfg_i.dff}}, tx_data_i[7:0]};
        end else if (shift_tx_i) begin
            if (cfg_i.lsbfirst) begin
                tx_q <= {1'b0, tx_q[15:1]};
            end else begin
                tx_q <= {tx_q[14:0], 1'b0};
            end
        end
    end

    always_comb begin
        if (cfg_i.lsbfirst) begin
            mosi_pre = tx_q[0];
        end else if (cfg_i.dff) begin
            mosi_pre = tx_q[15];
        end else begin
            mosi_pre = tx_q[7];
        end
    end

    // sampling lags the strobe to match the registered mosi
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mosi_o   <= 1'b0;
            sample_q <= 1'b0;
            rx_pop_q <= 1'b0;
        end else begin
            mosi_o   <= mosi_pre;
            sample_q <= sample_rx_i;
            rx_pop_q <= rx_pop_i;
        end
    end

    // cleared as the buffer takes the word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rx_q <= 16'h0;
        end else if (rx_pop_q) begin
            rx_q <= 16'h0;
        end else if (sample_q) begin
            case ({cfg_i.lsbfirst, cfg_i.dff})
                2'b00:   rx_q <= {8'h0, rx_q[6:0], miso_i};
                2'b01:   rx_q <= {rx_q[14:0], miso_i};
                2'b10:   rx_q <= {8'h0, miso_i, rx_q[7:1]};
                default: rx_q <= {miso_i, rx_q[15:1]};
            endcase
        end
    end

    assign rx_data_o = rx_q;

endmodule

/* design/spi.sv */
`timescale 1ns/1ns

module spi (
    input  logic              clk,
    input  logic              rstn,
    input  spi_pkg::apb_req_t apb_req_i,
    output spi_pkg::apb_rsp_t apb_rsp_o,
    output logic              sclk_o,
    output logic              nss_o,
    output logic              mosi_o,
    input  logic              miso_i,
    input  logic              dma_rxreq_i,
    output logic              dma_rxne_o,
    output logic [15:0]       dma_rxbuff_o,
    input  logic              dma_txreq_i,
    output logic              dma_txe_o,
    input  logic [15:0]       dma_txbuff_i,
    output logic              irq_o
);

    spi_pkg::spi_cfg_t cfg;
    logic              tx_full;
    logic [15:0]       tx_data;
    logic [15:0]       rx_data;
    logic              tx_pop;
    logic              rx_pop;
    logic              busy;
    logic              load;
    logic              shift_tx;
    logic              sample_rx;

    spi_regs u_regs (
        .clk          (clk),
        .rstn         (rstn),
        .apb_req_i    (apb_req_i),
        .tx_pop_i     (tx_pop),
        .rx_pop_i     (rx_pop),
        .busy_i       (busy),
        .rx_data_i    (rx_data),
        .dma_txreq_i  (dma_txreq_i),
        .dma_txbuff_i (dma_txbuff_i),
        .dma_rxreq_i  (dma_rxreq_i),
        .apb_rsp_o    (apb_rsp_o),
        .cfg_o        (cfg),
        .tx_full_o    (tx_full),
        .tx_data_o    (tx_data),
        .dma_txe_o    (dma_txe_o),
        .dma_rxne_o   (dma_rxne_o),
        .dma_rxbuff_o (dma_rxbuff_o),
        .irq_o        (irq_o)
    );

    // nss gating by ssoe happens in the engine
    spi_engine u_engine (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_i       (cfg),
        .tx_full_i   (tx_full),
        .tx_pop_o    (tx_pop),
        .rx_pop_o    (rx_pop),
        .busy_o      (busy),
        .load_o      (load),
        .shift_tx_o  (shift_tx),
        .sample_rx_o (sample_rx),
        .sclk_o      (sclk_o),
        .nss_o       (nss_o)
    );

    spi_shifter u_shifter (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_i       (cfg),
        .load_i      (load),
        .shift_tx_i  (shift_tx),
        .sample_rx_i (sample_rx),
        .rx_pop_i    (rx_pop),
        .tx_data_i   (tx_data),
        .miso_i      (miso_i),
        .mosi_o      (mosi_o),
        .rx_data_o   (rx_data)
    );

endmodule

/* tests/spi_assertions.sv */
`timescale 1ns/1ns

module spi_assertions (
    input logic              clk,
    input logic              rstn,
    input spi_pkg::apb_req_t apb_req_i,
    input spi_pkg::apb_rsp_t apb_rsp_i,
    input spi_pkg::spi_cfg_t cfg_i,
    input logic              tx_pop_i,
    input logic              sclk_i,
    input logic              nss_i,
    input logic              dma_txe_i,
    input logic              dma_rxne_i,
    input logic              irq_i
);

    int   fail_cnt = 0;
    logic cr2_write;
    logic sr_read;
    logic txeie_q;
    logic rxneie_q;

    assign cr2_write = apb_req_i.psel & ~apb_req_i.penable & apb_req_i.pwrite &
                       (apb_req_i.paddr == spi_pkg::SPI_CR2);
    assign sr_read   = apb_req_i.psel & ~apb_req_i.penable & ~apb_req_i.pwrite &
                       (apb_req_i.paddr == spi_pkg::SPI_SR);

    // txeie and rxneie as written on the bus
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            txeie_q  <= 1'b0;
            rxneie_q <= 1'b0;
        end else if (cr2_write) begin
            txeie_q  <= apb_req_i.pwdata[7];
            rxneie_q <= apb_req_i.pwdata[6];
        end
    end

    a_sclk_idle: assert property (@(posedge clk) disable iff (!rstn)
        (nss_i && $past(cfg_i.ssoe)) |-> (sclk_i == $past(cfg_i.cpol)))
    else begin
        $error("sclk left its idle level while nss was high");
        fail_cnt++;
    end

    a_sr_flags: assert property (@(posedge clk) disable iff (!rstn)
        $past(sr_read) |-> (apb_rsp_i.prdata[1:0] == $past({dma_rxne_i, dma_txe_i})))
    else begin
        $error("SR txe or rxne differs from the DMA flag outputs");
        fail_cnt++;
    end

    a_irq_rule: assert property (@(posedge clk) disable iff (!rstn)
        irq_i == ((txeie_q & dma_txe_i) | (rxneie_q & dma_rxne_i)))
    else begin
        $error("irq does not match the enabled flags");
        fail_cnt++;
    end

    // txe only comes back through the engine taking the word
    a_txe_rise: assert property (@(posedge clk) disable iff (!rstn)
        $rose(dma_txe_i) |-> $past(tx_pop_i))
    else begin
        $error("txe rose without an engine pop in the cycle before");
        fail_cnt++;
    end

endmodule

/* tests/spi_tb.sv */
`timescale 1ns/1ns

module spi_tb;

    localparam int CYCLE_LIMIT = 20000;

    logic              clk = 1'b0;
    logic              rstn;
    spi_pkg::apb_req_t apb_req;
    spi_pkg::apb_rsp_t apb_rsp;
    logic              sclk;
    logic              nss;
    logic              mosi;
    logic              miso;
    logic              dma_rxreq;
    logic              dma_rxne;
    logic [15:0]       dma_rxbuff;
    logic              dma_txreq;
    logic              dma_txe;
    logic [15:0]       dma_txbuff;
    logic              irq;

    integer seed = 32'hee0c7e1d;
    int     cycles;
    int     errors;
    int     checks;

    // loopback
    assign miso = mosi;

    spi UUT (
        .clk          (clk),
        .rstn         (rstn),
        .apb_req_i    (apb_req),
        .apb_rsp_o    (apb_rsp),
        .sclk_o       (sclk),
        .nss_o        (nss),
        .mosi_o       (mosi),
        .miso_i       (miso),
        .dma_rxreq_i  (dma_rxreq),
        .dma_rxne_o   (dma_rxne),
        .dma_rxbuff_o (dma_rxbuff),
        .dma_txreq_i  (dma_txreq),
        .dma_txe_o    (dma_txe),
        .dma_txbuff_i (dma_txbuff),
        .irq_o        (irq)
    );

    bind spi spi_assertions u_sva (
        .clk        (clk),
        .rstn       (rstn),
        .apb_req_i  (apb_req_i),
        .apb_rsp_i  (apb_rsp_o),
        .cfg_i      (cfg),
        .tx_pop_i   (tx_pop),
        .sclk_i     (sclk_o),
        .nss_i      (nss_o),
        .dma_txe_i  (dma_txe_o),
        .dma_rxne_i (dma_rxne_o),
        .irq_i      (irq_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // CR1 word from its bit fields
    function automatic logic [31:0] cr1_word(input logic cpha, input logic cpol,
                                             input logic [2:0] br, input logic spe,
                                             input logic lsb, input logic dff);
        logic [31:0] w;
        w      = 32'h0;
        w[0]   = cpha;
        w[1]   = cpol;
        w[5:3] = br;
        w[6]   = spe;
        w[7]   = lsb;
        w[11]  = dff;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b1;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= 32'h0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic read_check(input string name, input logic [11:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        apb_read(addr, data);
        check_value(name, expected, data);
    endtask

    task automatic wait_txe();
        @(negedge clk);
        while (!dma_txe) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_rxne();
        @(negedge clk);
        while (!dma_rxne) begin
            @(negedge clk);
        end
    endtask

    task automatic dma_send(input logic [15:0] word);
        @(posedge clk);
        dma_txreq  <= 1'b1;
        dma_txbuff <= word;
        @(posedge clk);
        dma_txreq  <= 1'b0;
    endtask

    task automatic dma_take();
        @(posedge clk);
        dma_rxreq <= 1'b1;
        @(posedge clk);
        dma_rxreq <= 1'b0;
    endtask

    // 8 bit frames return only the low byte
    task automatic loopback(input string name, input logic [15:0] word, input logic dff);
        logic [31:0] expected;
        expected = dff ? {16'h0, word} : {24'h0, word[7:0]};
        wait_txe();
        apb_write(spi_pkg::SPI_DR, {16'h0, word});
        wait_rxne();
        read_check(name, spi_pkg::SPI_DR, expected);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [15:0] word;
        logic [15:0] first;
        logic [15:0] second;
        rstn       = 1'b0;
        apb_req    = '0;
        dma_rxreq  = 1'b0;
        dma_txreq  = 1'b0;
        dma_txbuff = 16'h0;
        cycles     = 0;
        errors     = 0;
        checks     = 0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        read_check("reset_cr1", spi_pkg::SPI_CR1, 32'h4);
        read_check("reset_cr2", spi_pkg::SPI_CR2, 32'h4);
        read_check("reset_sr", spi_pkg::SPI_SR, 32'h1);
        @(negedge clk);
        check_value("reset_nss", 32'h1, {31'h0, nss});
        check_value("reset_irq", 32'h0, {31'h0, irq});

        for (int mode = 0; mode < 4; mode++) begin
            apb_write(spi_pkg::SPI_CR1, cr1_word(mode[0], mode[1], 3'd1, 1'b1, 1'b0, 1'b0));
            rnd  = $random(seed);
            word = rnd[15:0];
            loopback($sformatf("mode%0d_loopback", mode), word, 1'b0);
            apb_write(spi_pkg::SPI_CR1, cr1_word(mode[0], mode[1], 3'd1, 1'b0, 1'b0, 1'b0));
        end

        // format change while enabled must not stick
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b0, 1'b0, 3'd2, 1'b1, 1'b1, 1'b1));
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b0, 1'b0, 3'd0, 1'b1, 1'b0, 1'b0));
        read_check("cr1_locked", spi_pkg::SPI_CR1,
                   cr1_word(1'b0, 1'b0, 3'd2, 1'b1, 1'b1, 1'b1) | 32'h4);
        rnd  = $random(seed);
        word = rnd[15:0];
        loopback("lsb16_loopback", word, 1'b1);
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b0, 1'b0, 3'd2, 1'b0, 1'b1, 1'b1));

        // second word queued behind the first in cpha 1
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b1, 1'b0, 3'd0, 1'b1, 1'b0, 1'b1));
        rnd    = $random(seed);
        first  = rnd[15:0];
        rnd    = $random(seed);
        second = rnd[15:0];
        wait_txe();
        apb_write(spi_pkg::SPI_DR, {16'h0, first});
        wait_txe();
        apb_write(spi_pkg::SPI_DR, {16'h0, second});
        wait_rxne();
        read_check("chain_first", spi_pkg::SPI_DR, {16'h0, first});
        wait_rxne();
        read_check("chain_second", spi_pkg::SPI_DR, {16'h0, second});
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b1, 1'b0, 3'd0, 1'b0, 1'b0, 1'b1));

        // bits 4:3 are not implemented and read back as zero
        apb_write(spi_pkg::SPI_CR2, 32'h3F);
        read_check("cr2_write", spi_pkg::SPI_CR2, 32'h27);
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b0, 1'b1, 3'd1, 1'b1, 1'b0, 1'b1));
        rnd  = $random(seed);
        word = rnd[15:0];
        wait_txe();
        dma_send(word);
        wait_rxne();
        check_value("dma_rxbuff", {16'h0, word}, {16'h0, dma_rxbuff});
        read_check("dma_sr_full", spi_pkg::SPI_SR, 32'h3);
        dma_take();
        @(negedge clk);
        check_value("dma_rxne_clear", 32'h0, {31'h0, dma_rxne});
        read_check("dma_sr_empty", spi_pkg::SPI_SR, 32'h1);
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b0, 1'b1, 3'd1, 1'b0, 1'b0, 1'b1));
        apb_write(spi_pkg::SPI_CR2, 32'h04);

        // txeie before rxneie
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b1, 1'b1, 3'd0, 1'b1, 1'b0, 1'b0));
        apb_write(spi_pkg::SPI_CR2, 32'h84);
        @(negedge clk);
        check_value("irq_txe", 32'h1, {31'h0, irq});
        rnd  = $random(seed);
        word = rnd[15:0];
        wait_txe();
        apb_write(spi_pkg::SPI_DR, {16'h0, word});
        wait_rxne();
        apb_write(spi_pkg::SPI_CR2, 32'h44);
        @(negedge clk);
        check_value("irq_rxne", 32'h1, {31'h0, irq});
        read_check("irq_data", spi_pkg::SPI_DR, {24'h0, word[7:0]});
        @(negedge clk);
        check_value("irq_cleared", 32'h0, {31'h0, irq});
        apb_write(spi_pkg::SPI_CR2, 32'h04);
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b1, 1'b1, 3'd0, 1'b0, 1'b0, 1'b0));

        // first word stays in the buffer while the engine is off
        rnd    = $random(seed);
        first  = rnd[15:0];
        rnd    = $random(seed);
        second = rnd[15:0];
        apb_write(spi_pkg::SPI_DR, {16'h0, first});
        read_check("drop_sr", spi_pkg::SPI_SR, 32'h0);
        apb_write(spi_pkg::SPI_DR, {16'h0, second});
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b0, 1'b0, 3'd3, 1'b1, 1'b0, 1'b1));
        // slow 16 bit frame still on the wire after the pop
        wait_txe();
        read_check("drop_sr_busy", spi_pkg::SPI_SR, 32'h81);
        wait_rxne();
        read_check("drop_keeps_first", spi_pkg::SPI_DR, {16'h0, first});
        apb_write(spi_pkg::SPI_CR1, cr1_word(1'b0, 1'b0, 3'd3, 1'b0, 1'b0, 1'b1));

        repeat (4) @(posedge clk);
        $display("%0d checks, %0d read errors, %0d assertion failures",
                 checks, errors, UUT.u_sva.fail_cnt);
        if (errors == 0 && UUT.u_sva.fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* src.f */
design/spi_pkg.sv
design/spi_regs.sv
design/spi_engine.sv
design/spi_shifter.sv
design/spi.sv
tests/spi_assertions.sv
tests/spi_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module spi_tb -f src.f -o spi_tb_sim

output=$(./obj_dir/spi_tb_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
